// ==== common/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// address layout
	// --------------------------------------------------
	// word address = { tag, word-in-block }
	localparam int WORD_ADDR_W = 16;  // word addressed, not byte
	localparam int BLOCK_W     = 2;   // word-in-block index bits
	localparam int BLOCK_WORDS = 4;   // words per line

	// cache capacity
	// --------------------------------------------------
	localparam int LINES  = 4;        // fully associative, any block in any line
	localparam int LINE_W = 2;

	// whole block number acts as the tag
	localparam int TAG_W = WORD_ADDR_W - BLOCK_W;

	typedef logic [31:0]          word_t;
	typedef logic [TAG_W-1:0]     tag_t;
	typedef logic [LINE_W-1:0]    line_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;

endpackage

// ==== common/cache_bus_pkg.sv ====
package cache_bus_pkg;

	import cache_geom_pkg::*;

	// core side, wishbone classic slave
	// --------------------------------------------------
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;   // 1 = store
		word_addr_t adr;
		word_t      dat;  // store data
	} core_req_t;

	typedef struct packed {
		logic  ack;   // single cycle
		word_t dat;   // load data, valid with ack
	} core_rsp_t;

	// memory side, wishbone classic master
	// --------------------------------------------------
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		word_addr_t adr;
		word_t      dat;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_t;

	// block command, ctrl -> mem port
	// --------------------------------------------------
	typedef struct packed {
		logic       we;   // 1 = writeback, 0 = fill
		word_addr_t adr;  // block aligned, low BLOCK_W bits zero
	} mem_cmd_t;

endpackage

// ==== verilog/xfer_fifo.sv ====
`timescale 1ns/1ns

module xfer_fifo #(
	parameter type T     = logic [31:0],
	parameter int  DEPTH = 4             // power of two
)(
	input  logic clock_i,
	input  logic resetn_i,

	input  logic push_i,
	input  T     push_data_i,
	output logic full_o,

	input  logic pop_i,
	output T     pop_data_o,   // head, valid while !empty_o
	output logic empty_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T              mem_q [2**AW];  // one slot per pointer value, DEPTH 1 included
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0]   count_q;     // one extra bit to tell full from empty

	logic          do_push;
	logic          do_pop;

	assign full_o  = (count_q == (AW+1)'(DEPTH));
	assign empty_o = (count_q == '0);

	assign do_push = push_i && !full_o;   // ignored when full
	assign do_pop  = pop_i && !empty_o;

	assign pop_data_o = mem_q[rd_ptr_q];

	// pointers wrap naturally at power of two depth
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !do_pop)      count_q <= count_q + 1'b1;
			else if (do_pop && !do_push) count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push) mem_q[wr_ptr_q] <= push_data_i;
	end

endmodule

// ==== cache_ctrl/tag_cam.sv ====
`timescale 1ns/1ns

module tag_cam import cache_geom_pkg::*; (
	input  logic  clock_i,
	input  logic  resetn_i,

	// associative search
	input  tag_t  search_tag_i,
	output logic  hit_o,
	output line_t hit_line_o,

	// tag install on refill
	input  logic  wr_i,
	input  line_t wr_line_i,
	input  tag_t  wr_tag_i,

	// victim readback
	input  line_t rd_line_i,
	output tag_t  rd_tag_o,
	output logic  rd_valid_o
);

	tag_t             tag_q [LINES];
	logic [LINES-1:0] valid_q;

	// compare against every line at once
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < LINES; i++) begin
			if (valid_q[i] && (tag_q[i] == search_tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = line_t'(i);  // tags unique, at most one match
			end
		end
	end

	assign rd_tag_o   = tag_q[rd_line_i];
	assign rd_valid_o = valid_q[rd_line_i];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wr_i) begin
			valid_q[wr_line_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (wr_i) tag_q[wr_line_i] <= wr_tag_i;  // new tag for the refilled line
	end

endmodule

// ==== cache_ctrl/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl import cache_geom_pkg::*, cache_bus_pkg::*; (
	input  logic      clock_i,
	input  logic      resetn_i,

	// core port
	input  core_req_t core_req_i,
	output core_rsp_t core_rsp_o,

	// command buffer
	output logic      cmd_push_o,
	output mem_cmd_t  cmd_o,
	input  logic      cmd_full_i,

	// writeback buffer
	output logic      wb_push_o,
	output word_t     wb_data_o,
	input  logic      wb_full_i,

	// fill buffer
	output logic      fill_pop_o,
	input  word_t     fill_data_i,
	input  logic      fill_empty_i
);

	typedef enum logic [2:0] {
		ST_LOOKUP,     // idle, tag search on request
		ST_WB_CMD,     // issue writeback if victim dirty
		ST_WB_DATA,    // stream victim words out
		ST_FILL_CMD,   // issue block read
		ST_FILL_DATA   // write fill words into victim
	} state_t;

	state_t                     state_q;
	logic [BLOCK_W-1:0]         cnt_q;     // word within block transfer
	logic [LINES-1:0]           dirty_q;
	line_t                      repl_q;    // victim line once a miss starts
	core_rsp_t                  rsp_q;
	word_t                      data_q [LINES*BLOCK_WORDS];

	logic                       req_live;
	tag_t                       req_tag;
	logic                       hit;
	line_t                      hit_line;
	tag_t                       victim_tag;
	logic                       victim_valid;
	logic                       victim_dirty;
	logic                       last_word;
	logic [LINE_W+BLOCK_W-1:0]  hit_idx;
	logic [LINE_W+BLOCK_W-1:0]  xfer_idx;
	logic                       tag_wr;

	// lookup
	// --------------------------------------------------
	// rsp_q.ack guard keeps the acked request from being served twice
	assign req_live = core_req_i.cyc && core_req_i.stb && !rsp_q.ack;
	assign req_tag  = core_req_i.adr[WORD_ADDR_W-1:BLOCK_W];
	assign hit_idx  = {hit_line, core_req_i.adr[BLOCK_W-1:0]};
	assign xfer_idx = {repl_q, cnt_q};  // victim line, current word

	assign last_word    = (cnt_q == BLOCK_W'(BLOCK_WORDS - 1));
	assign victim_dirty = victim_valid && dirty_q[repl_q];

	tag_cam tag_cam_i (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.search_tag_i (req_tag),
		.hit_o        (hit),
		.hit_line_o   (hit_line),
		.wr_i         (tag_wr),
		.wr_line_i    (repl_q),
		.wr_tag_i     (req_tag),       // core holds adr through the miss
		.rd_line_i    (repl_q),
		.rd_tag_o     (victim_tag),
		.rd_valid_o   (victim_valid)
	);

	// buffer side strobes
	// --------------------------------------------------
	always_comb begin
		cmd_push_o = 1'b0;
		cmd_o.we   = 1'b0;
		cmd_o.adr  = {req_tag, {BLOCK_W{1'b0}}};   // fill address by default
		if (state_q == ST_WB_CMD) begin
			cmd_push_o = victim_dirty && !cmd_full_i;
			cmd_o.we   = 1'b1;
			cmd_o.adr  = {victim_tag, {BLOCK_W{1'b0}}};
		end else if (state_q == ST_FILL_CMD) begin
			cmd_push_o = !cmd_full_i;
		end
	end

	assign wb_push_o  = (state_q == ST_WB_DATA) && !wb_full_i;
	assign wb_data_o  = data_q[xfer_idx];
	assign fill_pop_o = (state_q == ST_FILL_DATA) && !fill_empty_i;
	assign tag_wr     = fill_pop_o && last_word;  // tag lands with the last word

	assign core_rsp_o = rsp_q;

	// control fsm
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q   <= ST_LOOKUP;
			cnt_q     <= '0;
			dirty_q   <= '0;
			repl_q    <= line_t'(LINES - 1);  // first miss wraps to line 0
			rsp_q.ack <= 1'b0;
		end else begin
			rsp_q.ack <= 1'b0;
			case (state_q)
				ST_LOOKUP: begin
					if (req_live && hit) begin
						rsp_q.ack <= 1'b1;
						if (core_req_i.we) dirty_q[hit_line] <= 1'b1;
					end else if (req_live) begin
						repl_q  <= repl_q + 1'b1;  // round robin victim
						state_q <= ST_WB_CMD;
					end
				end
				ST_WB_CMD: begin
					cnt_q <= '0;
					if (!victim_dirty) state_q <= ST_FILL_CMD;  // clean, skip writeback
					else if (!cmd_full_i) state_q <= ST_WB_DATA;
				end
				ST_WB_DATA: begin
					if (wb_push_o) begin
						cnt_q <= cnt_q + 1'b1;
						if (last_word) state_q <= ST_FILL_CMD;
					end
				end
				ST_FILL_CMD: begin
					cnt_q <= '0;
					if (!cmd_full_i) state_q <= ST_FILL_DATA;
				end
				ST_FILL_DATA: begin
					if (fill_pop_o) begin
						cnt_q <= cnt_q + 1'b1;
						if (last_word) begin
							dirty_q[repl_q] <= 1'b0;
							state_q         <= ST_LOOKUP;  // now hits the held request
						end
					end
				end
				default: state_q <= ST_LOOKUP;
			endcase
		end
	end

	// data array and read data
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (state_q == ST_LOOKUP && req_live && hit) begin
			rsp_q.dat <= data_q[hit_idx];   // old word on a store, ignored by core
			if (core_req_i.we) data_q[hit_idx] <= core_req_i.dat;
		end
		if (fill_pop_o) data_q[xfer_idx] <= fill_data_i;
	end

endmodule

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ns

module mem_port import cache_geom_pkg::*, cache_bus_pkg::*; (
	input  logic     clock_i,
	input  logic     resetn_i,

	// command buffer
	output logic     cmd_pop_o,
	input  mem_cmd_t cmd_i,
	input  logic     cmd_empty_i,

	// writeback words in
	output logic     wb_pop_o,
	input  word_t    wb_data_i,
	input  logic     wb_empty_i,

	// fill words out
	output logic     fill_push_o,
	output word_t    fill_data_o,
	input  logic     fill_full_i,

	// wishbone classic master
	output wb_m2s_t  mem_m2s_o,
	input  wb_s2m_t  mem_s2m_i
);

	typedef enum logic [1:0] {
		MP_IDLE,   // wait for a command
		MP_GAP,    // between words, bus idle
		MP_BUS     // word cycle held until ack
	} mp_state_t;

	mp_state_t          state_q;
	logic [BLOCK_W-1:0] word_cnt_q;
	wb_m2s_t            m2s_q;

	logic               word_ack;
	logic               last_word;
	logic               can_start;

	// command stays at fifo head until the block is done
	assign word_ack  = (state_q == MP_BUS) && mem_s2m_i.ack;
	assign last_word = (word_cnt_q == BLOCK_W'(BLOCK_WORDS - 1));

	// write needs data ready, read needs room for the word
	assign can_start = cmd_i.we ? !wb_empty_i : !fill_full_i;

	assign wb_pop_o    = word_ack && cmd_i.we;
	assign fill_push_o = word_ack && !cmd_i.we;
	assign fill_data_o = mem_s2m_i.dat;
	assign cmd_pop_o   = word_ack && last_word;

	assign mem_m2s_o = m2s_q;

	// word sequencer
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= MP_IDLE;
			word_cnt_q <= '0;
			m2s_q.cyc  <= 1'b0;
			m2s_q.stb  <= 1'b0;
		end else begin
			case (state_q)
				MP_IDLE: begin
					if (!cmd_empty_i) state_q <= MP_GAP;
				end
				MP_GAP: begin
					if (can_start) begin
						m2s_q.cyc <= 1'b1;
						m2s_q.stb <= 1'b1;
						state_q   <= MP_BUS;
					end
				end
				MP_BUS: begin
					if (mem_s2m_i.ack) begin
						m2s_q.cyc  <= 1'b0;   // drop for a cycle between words
						m2s_q.stb  <= 1'b0;
						word_cnt_q <= word_cnt_q + 1'b1;   // wraps to 0 after last
						state_q    <= last_word ? MP_IDLE : MP_GAP;
					end
				end
				default: state_q <= MP_IDLE;
			endcase
		end
	end

	// address and write data, latched as the cycle opens
	always_ff @(posedge clock_i) begin
		if (state_q == MP_GAP && can_start) begin
			m2s_q.we  <= cmd_i.we;
			m2s_q.adr <= {cmd_i.adr[WORD_ADDR_W-1:BLOCK_W], word_cnt_q};
			m2s_q.dat <= wb_data_i;   // don't care on reads
		end
	end

endmodule

// ==== verilog/fa_cache_top.sv ====
`timescale 1ns/1ns

module fa_cache_top import cache_geom_pkg::*, cache_bus_pkg::*; (
	input  logic      clock_i,
	input  logic      resetn_i,
	input  core_req_t core_req_i,
	output core_rsp_t core_rsp_o,
	output wb_m2s_t   mem_m2s_o,
	input  wb_s2m_t   mem_s2m_i
);

	// ctrl -> cmd fifo -> mem port
	logic     cmd_push, cmd_full, cmd_pop, cmd_empty;
	mem_cmd_t cmd_in, cmd_out;

	// ctrl -> wb fifo -> mem port
	logic     wb_push, wb_full, wb_pop, wb_empty;
	word_t    wb_in, wb_out;

	// mem port -> fill fifo -> ctrl
	logic     fill_push, fill_full, fill_pop, fill_empty;
	word_t    fill_in, fill_out;

	cache_ctrl cache_ctrl_i (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.core_req_i (core_req_i), .core_rsp_o (core_rsp_o),
		.cmd_push_o (cmd_push), .cmd_o (cmd_in), .cmd_full_i (cmd_full),
		.wb_push_o (wb_push), .wb_data_o (wb_in), .wb_full_i (wb_full),
		.fill_pop_o (fill_pop), .fill_data_i (fill_out), .fill_empty_i (fill_empty)
	);

	// one block deep each
	// --------------------------------------------------
	xfer_fifo #(.T(mem_cmd_t), .DEPTH(BLOCK_WORDS)) cmd_fifo (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.push_i (cmd_push), .push_data_i (cmd_in), .full_o (cmd_full),
		.pop_i (cmd_pop), .pop_data_o (cmd_out), .empty_o (cmd_empty)
	);

	xfer_fifo #(.T(word_t), .DEPTH(BLOCK_WORDS)) wb_fifo (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.push_i (wb_push), .push_data_i (wb_in), .full_o (wb_full),
		.pop_i (wb_pop), .pop_data_o (wb_out), .empty_o (wb_empty)
	);

	xfer_fifo #(.T(word_t), .DEPTH(BLOCK_WORDS)) fill_fifo (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.push_i (fill_push), .push_data_i (fill_in), .full_o (fill_full),
		.pop_i (fill_pop), .pop_data_o (fill_out), .empty_o (fill_empty)
	);

	mem_port mem_port_i (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.cmd_pop_o (cmd_pop), .cmd_i (cmd_out), .cmd_empty_i (cmd_empty),
		.wb_pop_o (wb_pop), .wb_data_i (wb_out), .wb_empty_i (wb_empty),
		.fill_push_o (fill_push), .fill_data_o (fill_in), .fill_full_i (fill_full),
		.mem_m2s_o (mem_m2s_o), .mem_s2m_i (mem_s2m_i)
	);

endmodule

// ==== tb/wb_mem_model.sv ====
`timescale 1ns/1ns

module wb_mem_model import cache_geom_pkg::*, cache_bus_pkg::*; (
	input  logic    clock_i,
	input  logic    resetn_i,
	input  wb_m2s_t m2s_i,
	output wb_s2m_t s2m_o
);

	localparam int SIZE = 1 << WORD_ADDR_W;   // whole word address space

	word_t      mem [SIZE];
	integer     seed;
	logic       busy_q;     // request seen, counting down
	logic [1:0] wait_q;     // idle cycles left before ack
	wb_s2m_t    s2m_q;

	assign s2m_o = s2m_q;

	// initial contents, every word tied to its own address
	initial begin
		seed = 20475;
		for (int a = 0; a < SIZE; a++) begin
			mem[a] = 32'h5A5A0000 ^ 32'(a);
		end
	end

	// classic slave
	// --------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			s2m_q.ack <= 1'b0;
			busy_q    <= 1'b0;
			wait_q    <= '0;
		end else begin
			s2m_q.ack <= 1'b0;   // one cycle pulse
			if (m2s_i.cyc && m2s_i.stb && !s2m_q.ack) begin
				if (!busy_q) begin
					busy_q <= 1'b1;
					wait_q <= 2'($random(seed));   // 0..3 extra cycles
				end else if (wait_q != 2'd0) begin
					wait_q <= wait_q - 2'd1;
				end else begin
					busy_q    <= 1'b0;
					s2m_q.ack <= 1'b1;
					if (m2s_i.we) mem[m2s_i.adr] = m2s_i.dat;
					else s2m_q.dat <= mem[m2s_i.adr];
				end
			end
		end
	end

endmodule

// ==== tb/fa_cache_tb.sv ====
`timescale 1ns/1ns

module fa_cache_tb import cache_geom_pkg::*, cache_bus_pkg::*; ();

	localparam int CLK_HALF    = 4;     // 8 ns period
	localparam int ACK_TIMEOUT = 200;   // cycles allowed per core access
	localparam int RAND_OPS    = 200;

	logic      clock;
	logic      resetn;
	core_req_t core_req;
	core_rsp_t core_rsp;
	wb_m2s_t   mem_m2s;
	wb_s2m_t   mem_s2m;

	integer    seed;
	int        checks;
	int        errors;
	logic      timed_out;              // dut stuck, skip remaining accesses
	word_t     shadow [word_addr_t];   // every core store so far

	fa_cache_top dut_i (
		.clock_i    (clock),
		.resetn_i   (resetn),
		.core_req_i (core_req),
		.core_rsp_o (core_rsp),
		.mem_m2s_o  (mem_m2s),
		.mem_s2m_i  (mem_s2m)
	);

	wb_mem_model mem_i (
		.clock_i  (clock),
		.resetn_i (resetn),
		.m2s_i    (mem_m2s),
		.s2m_o    (mem_s2m)
	);

	initial begin
		clock = 1'b0;
		forever #CLK_HALF clock = ~clock;
	end

	// reference and checking
	// --------------------------------------------------
	// stored value if any, else the memory fill pattern
	function automatic word_t expected_word(input word_addr_t adr);
		if (shadow.exists(adr)) return shadow[adr];
		return 32'h5A5A0000 ^ {16'h0000, adr};
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		if (errors == err_before) $display("test %0d %s: ok", num, name);
		else $display("test %0d %s: %0d errors", num, name, errors - err_before);
	endtask

	// every acked load against the reference, stores feed the shadow
	always @(negedge clock) begin
		if (resetn && core_rsp.ack === 1'b1) begin
			if (core_req.we) shadow[core_req.adr] = core_req.dat;
			else check_equal("core_rsp.dat", core_rsp.dat, expected_word(core_req.adr));
		end
	end

	// one classic cycle on the core port, lat counts edges until ack
	task automatic core_access(input logic store, input word_addr_t adr, input word_t wdat,
	                           output word_t rdat, output int lat);
		lat  = 0;
		rdat = '0;
		if (timed_out) return;
		@(posedge clock);
		core_req <= '{cyc: 1'b1, stb: 1'b1, we: store, adr: adr, dat: wdat};
		do begin
			@(posedge clock);
			lat++;
			@(negedge clock);   // sample away from the edge
		end while (core_rsp.ack !== 1'b1 && lat < ACK_TIMEOUT);
		if (core_rsp.ack !== 1'b1) begin
			$display("timeout: no core ack within %0d cycles, address %h", ACK_TIMEOUT, adr);
			timed_out = 1'b1;
			errors++;
		end
		rdat = core_rsp.dat;
		@(posedge clock);
		core_req <= '0;   // bus idle again
	endtask

	// test sequence
	// --------------------------------------------------
	initial begin
		word_t      rdat;
		int         lat;
		int         err0;
		logic       store;
		word_addr_t adr;
		word_t      wdat;
		seed      = 20475;
		checks    = 0;
		errors    = 0;
		timed_out = 1'b0;
		resetn   <= 1'b0;
		core_req <= '0;
		repeat (2) @(posedge clock);
		resetn <= 1'b1;

		err0 = errors;   // quiet bus, nothing requested
		repeat (8) begin
			@(negedge clock);
			check_equal("core_rsp.ack", 32'(core_rsp.ack), 0);
			check_equal("mem_m2s.cyc", 32'(mem_m2s.cyc), 0);
			check_equal("mem_m2s.stb", 32'(mem_m2s.stb), 0);
		end
		report_test(1, "idle after reset", err0);

		err0 = errors;
		core_access(1'b0, 16'h0041, '0, rdat, lat);
		check_equal("miss latency above one", 32'(lat > 1), 1);
		core_access(1'b0, 16'h0043, '0, rdat, lat);   // same block, must hit
		check_equal("hit latency", lat, 1);
		report_test(2, "cold read miss", err0);

		err0 = errors;
		core_access(1'b1, 16'h0042, 32'hCAFE0042, rdat, lat);
		core_access(1'b0, 16'h0042, '0, rdat, lat);
		check_equal("hit latency", lat, 1);
		report_test(3, "write hit then read hit", err0);

		err0 = errors;
		core_access(1'b1, 16'h0100, 32'hD1D70100, rdat, lat);
		for (int i = 1; i <= LINES; i++) begin
			core_access(1'b0, 16'h0100 + word_addr_t'(i * 16), '0, rdat, lat);
		end
		core_access(1'b0, 16'h0100, '0, rdat, lat);   // evicted, comes back from memory
		check_equal("core_rsp.dat", rdat, 32'hD1D70100);
		check_equal("reload miss latency above one", 32'(lat > 1), 1);
		report_test(4, "dirty eviction", err0);

		err0 = errors;   // eight blocks at 0x2000, twice the capacity
		for (int i = 0; i < RAND_OPS; i++) begin
			store = 1'($random(seed));
			adr   = 16'h2000 + word_addr_t'($random(seed) & 31);
			wdat  = $random(seed);
			core_access(store, adr, wdat, rdat, lat);
		end
		report_test(5, "random traffic", err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
common/cache_geom_pkg.sv
common/cache_bus_pkg.sv
verilog/xfer_fifo.sv
cache_ctrl/tag_cam.sv
cache_ctrl/cache_ctrl.sv
verilog/mem_port.sv
verilog/fa_cache_top.sv
tb/wb_mem_model.sv
tb/fa_cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench
VERILATOR ?= verilator
TOP       ?= fa_cache_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
